// ==== Bender.yml ====
package:
  name: dotp

export_include_dirs:
  - .

sources:
  - dotp_pkg.sv
  - dotp_decode.sv
  - dotp_mac_pipe.sv
  - dotp_result.sv
  - dotp_top.sv
  - target: test
    files:
      - dotp_assertions.sv
      - dotp_tb.sv

// ==== dotp_assertions.sv ====
// Concurrent checks for the dot-product unit, attached to dotp_top by bind
// Result hold under stall, quiet start after reset, credit bound and pipeline latency
`timescale 1ns/1ps
`default_nettype none

`include "dotp_cfg.svh"

module dotp_assertions (
   input wire logic            clk,
   input wire logic            rst,
   input wire logic            res_valid,
   input wire logic            res_ready,
   input wire dotp_pkg::elem_t res_data,
   input wire logic            issue_valid,
   input wire logic            mac_valid,
   input wire dotp_pkg::cnt_t  outstanding
);

   // Failed checks so far, read at the end of the run
   int fail_count = 0;

   // ==================================================
   // Result port
   // ==================================================

   // Stalled head stays put
   assert property (@(posedge clk) disable iff (rst)
      res_valid && !res_ready |=> res_valid && $stable(res_data))
   else begin
      $error("res_data changed or res_valid dropped while the sink stalled");
      fail_count++;
   end

   // Nothing can come out before the pipeline has filled
   assert property (@(posedge clk)
      $fell(rst) |-> !res_valid ##1 !res_valid ##1 !res_valid)
   else begin
      $error("res_valid rose too early after reset");
      fail_count++;
   end

   // ==================================================
   // Credits and pipeline
   // ==================================================

   assert property (@(posedge clk) disable iff (rst)
      outstanding <= dotp_pkg::cnt_t'(`DOTP_FIFO_DEPTH))
   else begin
      $error("outstanding result count above the buffer depth");
      fail_count++;
   end

   // Fixed latency both ways
   assert property (@(posedge clk) disable iff (rst)
      issue_valid |-> ##(`DOTP_MAC_LATENCY) mac_valid)
   else begin
      $error("issued command did not reach mac_valid on time");
      fail_count++;
   end

   assert property (@(posedge clk) disable iff (rst)
      mac_valid |-> $past(issue_valid, `DOTP_MAC_LATENCY))
   else begin
      $error("mac_valid without a matching issue");
      fail_count++;
   end

endmodule

bind dotp_top dotp_assertions u_assertions (
   .clk         (clk),
   .rst         (rst),
   .res_valid   (res_valid),
   .res_ready   (res_ready),
   .res_data    (res_data),
   .issue_valid (issue_valid),
   .mac_valid   (mac_valid),
   .outstanding (u_decode.outstanding)
);

`default_nettype wire

// ==== dotp_cfg.svh ====
// Build-time widths, depths and latency for the dot-product unit
// Included by the package and by every module that sizes logic from these values
`ifndef DOTP_CFG_SVH
`define DOTP_CFG_SVH

// ==================================================
// Data path
// ==================================================

// Element, product, sum and result width
`define DOTP_WIDTH 16

// Elements per command, taken as four adjacent pairs
`define DOTP_LANES 8

// ==================================================
// Timing and buffering
// ==================================================

// Registered stages from issue to the pipeline valid output
`define DOTP_MAC_LATENCY 4

// Result buffer entries, which also sets the credit pool
`define DOTP_FIFO_DEPTH 8

`endif

// ==== dotp_decode.sv ====
// Command front end of the dot-product unit
// Decodes opcodes, tracks result credits and registers accepted commands onto issue
`timescale 1ns/1ps
`default_nettype none

`include "dotp_cfg.svh"

module dotp_decode (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            cmd_valid,
   input  wire dotp_pkg::op_t   cmd_op,
   input  wire dotp_pkg::lanes_t cmd_data,
   output logic                 cmd_ready,
   input  wire logic            credit_return,
   output logic                 issue_valid,
   output dotp_pkg::op_t        issue_op,
   output dotp_pkg::lanes_t     issue_data
);

   // ==================================================
   // Opcode decode
   // ==================================================

   dotp_pkg::op_t  op_norm;
   logic           produces;
   logic           accept;
   logic           take_credit;
   logic           room;

   // Results in flight in the pipeline plus results parked in the FIFO
   dotp_pkg::cnt_t outstanding;

   // Reserved value 3 folds onto dot
   always_comb begin
      if (cmd_op == dotp_pkg::OP_ACC || cmd_op == dotp_pkg::OP_EMIT) begin
         op_norm = cmd_op;
      end else begin
         op_norm = dotp_pkg::OP_DOT;
      end
   end

   // Only accumulate stays silent on the result stream
   assign produces = (op_norm != dotp_pkg::OP_ACC);

   // ==================================================
   // Credit check and handshake
   // ==================================================

   // Free FIFO slot guaranteed for every result not yet returned
   assign room = (outstanding < dotp_pkg::cnt_t'(`DOTP_FIFO_DEPTH));

   // Accumulate never needs a slot, so it always passes
   assign cmd_ready   = !produces || room;
   assign accept      = cmd_valid && cmd_ready;
   assign take_credit = accept && produces;

   // Up on a producing accept, down on each pop, both may land together
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         outstanding <= '0;
      end else begin
         case ({take_credit, credit_return})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
         endcase
      end
   end

   // ==================================================
   // Issue register
   // ==================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= accept;
      end
   end

   // Payload only moves on an accepted command
   always_ff @(posedge clk) begin
      if (accept) begin
         issue_op   <= op_norm;
         issue_data <= cmd_data;
      end
   end

endmodule

`default_nettype wire

// ==== dotp_mac_pipe.sv ====
// Four-stage pair-multiply and adder-tree pipeline, never stalls
// Input register, four products, two partial sums, final sum, all wrapping
`timescale 1ns/1ps
`default_nettype none

`include "dotp_cfg.svh"

module dotp_mac_pipe (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire logic             issue_valid,
   input  wire dotp_pkg::lanes_t issue_data,
   output logic                  mac_valid,
   output dotp_pkg::elem_t       mac_sum
);

   localparam int W     = `DOTP_WIDTH;
   localparam int PAIRS = `DOTP_LANES / 2;

   // ==================================================
   // Data stages
   // ==================================================

   dotp_pkg::lanes_t in_r;
   dotp_pkg::elem_t  prod_r [PAIRS];
   dotp_pkg::elem_t  part_r [2];
   dotp_pkg::elem_t  sum_r;

   // Validity of each stage, one bit per register level
   logic [`DOTP_MAC_LATENCY-1:0] valid_d;

   // Data registers run freely, bubbles are tracked by valid_d
   always_ff @(posedge clk) begin
      // Stage 1
      in_r <= issue_data;

      // Stage 2, adjacent lanes multiplied and truncated
      for (int i = 0; i < PAIRS; i++) begin
         prod_r[i] <= dotp_pkg::elem_t'(in_r[(2*i)*W +: W] * in_r[(2*i+1)*W +: W]);
      end

      // Stage 3, first adder level
      part_r[0] <= prod_r[0] + prod_r[1];
      part_r[1] <= prod_r[2] + prod_r[3];

      // Stage 4, tree root
      sum_r <= part_r[0] + part_r[1];
   end

   // ==================================================
   // Valid delay line
   // ==================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_d <= '0;
      end else begin
         valid_d[0] <= issue_valid;
         for (int i = 1; i < `DOTP_MAC_LATENCY; i++) begin
            valid_d[i] <= valid_d[i-1];
         end
      end
   end

   // Last stage marks a finished sum
   assign mac_valid = valid_d[`DOTP_MAC_LATENCY-1];
   assign mac_sum   = sum_r;

endmodule

`default_nettype wire

// ==== dotp_pkg.sv ====
// Shared types and opcode values for the dot-product unit
// Referenced by scoped name from the decode, pipeline, result and top modules
`default_nettype none

`include "dotp_cfg.svh"

package dotp_pkg;

   // ==================================================
   // Data types
   // ==================================================

   // One element, one product, one partial sum or one result
   typedef logic [`DOTP_WIDTH-1:0] elem_t;

   // All elements of one command, lane 0 in the low bits
   typedef logic [`DOTP_LANES*`DOTP_WIDTH-1:0] lanes_t;

   // Outstanding result counter, must reach the full depth
   typedef logic [$clog2(`DOTP_FIFO_DEPTH+1)-1:0] cnt_t;

   // ==================================================
   // Opcodes
   // ==================================================

   typedef logic [1:0] op_t;

   // Sum goes straight to the result stream
   localparam op_t OP_DOT  = 2'd0;
   // Sum folds into the accumulator, no result
   localparam op_t OP_ACC  = 2'd1;
   // Sum folds in, total is emitted, accumulator clears
   localparam op_t OP_EMIT = 2'd2;

endpackage

`default_nettype wire

// ==== dotp_result.sv ====
// Back end of the dot-product unit with accumulator and result FIFO
// Aligns opcodes with pipeline sums, buffers results and returns one credit per pop
`timescale 1ns/1ps
`default_nettype none

`include "dotp_cfg.svh"

module dotp_result (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            issue_valid,
   input  wire dotp_pkg::op_t   issue_op,
   input  wire logic            mac_valid,
   input  wire dotp_pkg::elem_t mac_sum,
   output logic                 res_valid,
   input  wire logic            res_ready,
   output dotp_pkg::elem_t      res_data,
   output logic                 credit_return
);

   localparam int DEPTH = `DOTP_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   // ==================================================
   // Opcode alignment
   // ==================================================

   dotp_pkg::op_t op_d [`DOTP_MAC_LATENCY];
   dotp_pkg::op_t op_aligned;

   // Idle issue slots carry dot, which leaves the accumulator alone
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `DOTP_MAC_LATENCY; i++) begin
            op_d[i] <= dotp_pkg::OP_DOT;
         end
      end else begin
         op_d[0] <= issue_valid ? issue_op : dotp_pkg::OP_DOT;
         for (int i = 1; i < `DOTP_MAC_LATENCY; i++) begin
            op_d[i] <= op_d[i-1];
         end
      end
   end

   // Same stage count as the pipeline, so this matches mac_sum
   assign op_aligned = op_d[`DOTP_MAC_LATENCY-1];

   // ==================================================
   // Accumulator
   // ==================================================

   dotp_pkg::elem_t acc_r;
   dotp_pkg::elem_t acc_sum;
   dotp_pkg::elem_t fifo_wdata;
   logic            push;
   logic            pop;

   assign acc_sum = acc_r + mac_sum;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_r <= '0;
      end else if (mac_valid) begin
         if (op_aligned == dotp_pkg::OP_ACC) begin
            acc_r <= acc_sum;
         end else if (op_aligned == dotp_pkg::OP_EMIT) begin
            // Total leaves through the FIFO, next run starts at zero
            acc_r <= '0;
         end
      end
   end

   // Emit sends the new total, dot sends the raw sum
   assign fifo_wdata = (op_aligned == dotp_pkg::OP_EMIT) ? acc_sum : mac_sum;
   assign push       = mac_valid && (op_aligned != dotp_pkg::OP_ACC);

   // ==================================================
   // Result FIFO
   // ==================================================

   dotp_pkg::elem_t mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   dotp_pkg::cnt_t   count;

   // Credits keep push away from a full buffer
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= fifo_wdata;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Head entry holds still until it is taken
   assign res_valid     = (count != '0);
   assign res_data      = mem[rd_ptr];
   assign pop           = res_valid && res_ready;
   assign credit_return = pop;

endmodule

`default_nettype wire

// ==== dotp_tb.sv ====
// Testbench for the dot-product unit with a directed table, back-pressure and random traffic
// Results are checked in order against a model of the wrapping pair-product arithmetic
`timescale 1ns/1ps
`default_nettype none

`include "dotp_cfg.svh"

module dotp_tb;

   localparam int W             = `DOTP_WIDTH;
   localparam int N_ROWS        = 13;
   localparam int N_RANDOM      = 80;
   localparam int CMD_TIMEOUT   = 100;
   localparam int DRAIN_TIMEOUT = 400;

   // ==================================================
   // DUT signals and scoreboard
   // ==================================================

   logic             clk;
   logic             rst;
   logic             cmd_valid;
   dotp_pkg::op_t    cmd_op;
   dotp_pkg::lanes_t cmd_data;
   logic             cmd_ready;
   logic             res_valid;
   logic             res_ready;
   dotp_pkg::elem_t  res_data;

   // Model accumulator, follows the DUT in command order
   dotp_pkg::elem_t  model_acc;
   dotp_pkg::elem_t  exp_q [$];
   dotp_pkg::elem_t  mon_exp;
   int               mismatches;
   int               timeouts;
   int               results_seen;
   logic [31:0]      data_seed;
   logic [31:0]      ready_seed;
   logic             ready_random;

   // Directed rows, expected values filled in by the model
   dotp_pkg::op_t    tbl_op   [N_ROWS];
   dotp_pkg::lanes_t tbl_data [N_ROWS];
   logic             tbl_has  [N_ROWS];
   dotp_pkg::elem_t  tbl_exp  [N_ROWS];

   dotp_top UUT (
      .clk       (clk),
      .rst       (rst),
      .cmd_valid (cmd_valid),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data),
      .cmd_ready (cmd_ready),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .res_data  (res_data)
   );

   always #5 clk = ~clk;

   // ==================================================
   // Reference model and random source
   // ==================================================

   // Lane 0 lands in the low bits
   function automatic dotp_pkg::lanes_t pack8(input dotp_pkg::elem_t e0, e1, e2, e3,
                                              e4, e5, e6, e7);
      return {e7, e6, e5, e4, e3, e2, e1, e0};
   endfunction

   // Sum of adjacent pair products, modulo 2**W
   function automatic dotp_pkg::elem_t pair_sum(input dotp_pkg::lanes_t d);
      dotp_pkg::elem_t total;
      dotp_pkg::elem_t a;
      dotp_pkg::elem_t b;
      total = '0;
      for (int p = 0; p < `DOTP_LANES / 2; p++) begin
         a     = d[(2*p)*W +: W];
         b     = d[(2*p+1)*W +: W];
         total = dotp_pkg::elem_t'(total + dotp_pkg::elem_t'(a * b));
      end
      return total;
   endfunction

   // Reserved opcode counts as dot
   task automatic model_step(input dotp_pkg::op_t op, input dotp_pkg::lanes_t d,
                             output logic has, output dotp_pkg::elem_t val);
      dotp_pkg::elem_t s;
      s = pair_sum(d);
      if (op == dotp_pkg::OP_ACC) begin
         model_acc = model_acc + s;
         has       = 1'b0;
         val       = '0;
      end else if (op == dotp_pkg::OP_EMIT) begin
         val       = model_acc + s;
         model_acc = '0;
         has       = 1'b1;
      end else begin
         val = s;
         has = 1'b1;
      end
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic dotp_pkg::lanes_t rand_lanes();
      dotp_pkg::lanes_t d;
      for (int i = 0; i < `DOTP_LANES; i++) begin
         data_seed      = lcg_next(data_seed);
         d[i*W +: W]    = data_seed[31:16];
      end
      return d;
   endfunction

   // ==================================================
   // Stimulus table
   // ==================================================

   task automatic build_table();
      // Plain dot, then all-ones and large values that wrap
      tbl_op[0]   = dotp_pkg::OP_DOT;
      tbl_data[0] = pack8(1, 2, 3, 4, 5, 6, 7, 8);
      tbl_op[1]   = dotp_pkg::OP_DOT;
      tbl_data[1] = '1;
      tbl_op[2]   = dotp_pkg::OP_DOT;
      tbl_data[2] = pack8(16'h8000, 2, 16'h4000, 4, 16'h1234, 16'h00ff, 16'hfff0, 16'h0101);
      // Accumulate run closed by emit, second emit starts from zero
      tbl_op[3]   = dotp_pkg::OP_ACC;
      tbl_data[3] = pack8(10, 20, 30, 40, 50, 60, 70, 80);
      tbl_op[4]   = dotp_pkg::OP_ACC;
      tbl_data[4] = pack8(16'hffff, 16'hffff, 16'h7fff, 3, 9, 9, 1, 1);
      tbl_op[5]   = dotp_pkg::OP_ACC;
      tbl_data[5] = pack8(16'hc000, 16'h0400, 100, 200, 300, 400, 5, 6);
      tbl_op[6]   = dotp_pkg::OP_EMIT;
      tbl_data[6] = pack8(2, 3, 4, 5, 6, 7, 8, 9);
      tbl_op[7]   = dotp_pkg::OP_EMIT;
      tbl_data[7] = pack8(1, 1, 1, 1, 1, 1, 1, 1);
      // Dot and reserved opcode inside a run leave the total alone
      tbl_op[8]   = dotp_pkg::OP_ACC;
      tbl_data[8] = pack8(7, 7, 7, 7, 7, 7, 7, 7);
      tbl_op[9]   = dotp_pkg::OP_DOT;
      tbl_data[9] = pack8(11, 12, 13, 14, 15, 16, 17, 18);
      tbl_op[10]   = dotp_pkg::op_t'(3);
      tbl_data[10] = pack8(16'h0100, 16'h0100, 3, 5, 0, 9, 16'hfffe, 2);
      tbl_op[11]   = dotp_pkg::OP_ACC;
      tbl_data[11] = pack8(16'h1000, 16'h0010, 2, 2, 2, 2, 2, 2);
      tbl_op[12]   = dotp_pkg::OP_EMIT;
      tbl_data[12] = pack8(0, 0, 0, 0, 0, 0, 1, 1);
      for (int i = 0; i < N_ROWS; i++) begin
         model_step(tbl_op[i], tbl_data[i], tbl_has[i], tbl_exp[i]);
      end
   endtask

   // ==================================================
   // Drivers and monitor
   // ==================================================

   // Holds the command until accepted, then queues its expected result
   task automatic send_cmd(input dotp_pkg::op_t op, input dotp_pkg::lanes_t d,
                           input logic has, input dotp_pkg::elem_t val);
      int waited;
      waited    = 0;
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_data  = d;
      @(negedge clk);
      while (!cmd_ready && waited < CMD_TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (!cmd_ready) begin
         $display("Timeout: command with opcode %0d was never accepted", op);
         timeouts++;
      end else if (has) begin
         exp_q.push_back(val);
      end
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d expected results never came out", exp_q.size());
         timeouts++;
      end
   endtask

   // Stable point between edges, transfer lands on the next rising edge
   always @(negedge clk) begin
      if (!rst && res_valid && res_ready) begin
         if (exp_q.size() == 0) begin
            $display("** Error at time %0t: result 0x%04h arrived with none expected",
                     $time, res_data);
            mismatches++;
         end else begin
            mon_exp = exp_q.pop_front();
            results_seen++;
            if (res_data !== mon_exp) begin
               $display("** Error at time %0t: result %0d is 0x%04h, expected 0x%04h",
                        $time, results_seen, res_data, mon_exp);
               mismatches++;
            end
         end
      end
   end

   // Random sink readiness, about three cycles in four
   always @(posedge clk) begin
      #1;
      if (ready_random) begin
         ready_seed = lcg_next(ready_seed);
         res_ready  = (ready_seed[30:29] != 2'b00);
      end
   end

   // ==================================================
   // Test phases
   // ==================================================

   task automatic backpressure_phase();
      logic             has;
      dotp_pkg::elem_t  val;
      dotp_pkg::lanes_t d;
      @(posedge clk);
      #1;
      res_ready = 1'b0;
      // Use up every credit
      for (int i = 0; i < `DOTP_FIFO_DEPTH; i++) begin
         d = rand_lanes();
         model_step(dotp_pkg::OP_DOT, d, has, val);
         send_cmd(dotp_pkg::OP_DOT, d, has, val);
      end
      // A producing command must now be refused
      cmd_valid = 1'b1;
      cmd_op    = dotp_pkg::OP_EMIT;
      cmd_data  = '1;
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         if (cmd_ready) begin
            $display("** Error at time %0t: cmd_ready high with no credit left", $time);
            mismatches++;
         end
      end
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
      // Accumulates still go through
      for (int i = 0; i < 3; i++) begin
         d = rand_lanes();
         model_step(dotp_pkg::OP_ACC, d, has, val);
         send_cmd(dotp_pkg::OP_ACC, d, has, val);
      end
      res_ready = 1'b1;
      for (int i = 0; i < 4; i++) begin
         d = rand_lanes();
         model_step((i == 3) ? dotp_pkg::OP_EMIT : dotp_pkg::OP_DOT, d, has, val);
         send_cmd((i == 3) ? dotp_pkg::OP_EMIT : dotp_pkg::OP_DOT, d, has, val);
      end
   endtask

   task automatic random_phase();
      logic             has;
      dotp_pkg::elem_t  val;
      dotp_pkg::lanes_t d;
      dotp_pkg::op_t    op;
      // Sink source switched between edges, first random ready lands after the next edge
      @(negedge clk);
      ready_random = 1'b1;
      @(posedge clk);
      #1;
      for (int i = 0; i < N_RANDOM; i++) begin
         data_seed = lcg_next(data_seed);
         op        = dotp_pkg::op_t'(data_seed[29:28]);
         d         = rand_lanes();
         model_step(op, d, has, val);
         send_cmd(op, d, has, val);
      end
      @(negedge clk);
      ready_random = 1'b0;
      @(posedge clk);
      #1;
      res_ready    = 1'b1;
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b1;
      cmd_valid    = 1'b0;
      cmd_op       = dotp_pkg::OP_DOT;
      cmd_data     = '0;
      res_ready    = 1'b0;
      model_acc    = '0;
      mismatches   = 0;
      timeouts     = 0;
      results_seen = 0;
      data_seed    = 32'd98;
      ready_seed   = 32'd98;
      ready_random = 1'b0;
      build_table();
      repeat (2) @(posedge clk);
      #1;
      rst       = 1'b0;
      res_ready = 1'b1;
      @(negedge clk);
      if (!cmd_ready || res_valid) begin
         $display("** Error at time %0t: wrong handshake levels after reset", $time);
         mismatches++;
      end
      @(posedge clk);
      #1;
      for (int i = 0; i < N_ROWS; i++) begin
         send_cmd(tbl_op[i], tbl_data[i], tbl_has[i], tbl_exp[i]);
      end
      wait_drain();
      backpressure_phase();
      wait_drain();
      random_phase();
      wait_drain();
      // Quiet tail so a stray extra result is caught
      repeat (10) @(negedge clk);
      $display("Results %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
               results_seen, mismatches, timeouts, UUT.u_assertions.fail_count);
      if (mismatches == 0 && timeouts == 0 && UUT.u_assertions.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== dotp_top.sv ====
// Top level of the streaming dot-product unit
// Command stream in, result stream out, credit flow kept internal
`timescale 1ns/1ps
`default_nettype none

module dotp_top (
   input  wire logic             clk,
   input  wire logic             rst,
   // Command stream
   input  wire logic             cmd_valid,
   input  wire dotp_pkg::op_t    cmd_op,
   input  wire dotp_pkg::lanes_t cmd_data,
   output logic                  cmd_ready,
   // Result stream
   output logic                  res_valid,
   input  wire logic             res_ready,
   output dotp_pkg::elem_t       res_data
);

   // ==================================================
   // Internal wires
   // ==================================================

   // Decode to pipeline and result
   logic             issue_valid;
   dotp_pkg::op_t    issue_op;
   dotp_pkg::lanes_t issue_data;

   // Pipeline to result
   logic             mac_valid;
   dotp_pkg::elem_t  mac_sum;

   // One pulse per result handed to the sink
   logic             credit_return;

   dotp_decode u_decode (
      .clk           (clk),
      .rst           (rst),
      .cmd_valid     (cmd_valid),
      .cmd_op        (cmd_op),
      .cmd_data      (cmd_data),
      .cmd_ready     (cmd_ready),
      .credit_return (credit_return),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .issue_data    (issue_data)
   );

   dotp_mac_pipe u_mac (
      .clk         (clk),
      .rst         (rst),
      .issue_valid (issue_valid),
      .issue_data  (issue_data),
      .mac_valid   (mac_valid),
      .mac_sum     (mac_sum)
   );

   dotp_result u_result (
      .clk           (clk),
      .rst           (rst),
      .issue_valid   (issue_valid),
      .issue_op      (issue_op),
      .mac_valid     (mac_valid),
      .mac_sum       (mac_sum),
      .res_valid     (res_valid),
      .res_ready     (res_ready),
      .res_data      (res_data),
      .credit_return (credit_return)
   );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
dotp_pkg.sv
dotp_decode.sv
dotp_mac_pipe.sv
dotp_result.sv
dotp_top.sv
dotp_assertions.sv
dotp_tb.sv
